//--- logic/matrix_params.svh
`ifndef MATRIX_PARAMS_SVH
`define MATRIX_PARAMS_SVH

// panel geometry
`define MATRIX_WIDTH 16
`define MATRIX_HEIGHT 8

// RGB565 pixels are sent as two bytes, high byte first
`define BYTES_PER_PIXEL 2

// one plane per bit of the 6-bit green channel
`define BRIGHTNESS_LEVELS 6

// derived address widths
`define COL_BITS $clog2(`MATRIX_WIDTH)
`define ROW_BITS $clog2(`MATRIX_HEIGHT)

// pixel address is {row, column}
`define PIXEL_ADDR_BITS (`ROW_BITS + `COL_BITS)

`endif

//--- logic/matrix_pkg.sv
`include "matrix_params.svh"

package matrix_pkg;

    // colour as stored in the frame memory
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // parser sees two bytes, scanner sees RGB565
    typedef union packed {
        logic [`BYTES_PER_PIXEL-1:0][7:0] bytes;
        rgb565_t                          color;
    } pixel_word_t;

    // one byte store from the line command
    typedef struct packed {
        logic                                 strobe;
        logic [`PIXEL_ADDR_BITS-1:0]          addr;
        logic [$clog2(`BYTES_PER_PIXEL)-1:0] byte_sel;
        logic [7:0]                           data;
    } fb_write_t;

    // scanner read request, held until granted
    typedef struct packed {
        logic                        req;
        logic [`PIXEL_ADDR_BITS-1:0] addr;
    } fb_read_t;

    typedef struct packed {
        logic                        enable;
        logic                        write;
        logic [`PIXEL_ADDR_BITS-1:0] addr;
        logic [`BYTES_PER_PIXEL-1:0] byte_en;
        pixel_word_t                 wdata;
    } mem_port_t;

    typedef struct packed {
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
        rgb565_t              color;
    } scan_pixel_t;

endpackage

//--- logic/command_parser.sv
`timescale 1ns/1ns
`include "matrix_params.svh"

module command_parser (
    input  logic                           clk_in,
    input  logic                           reset,
    input  logic [7:0]                     rx_data,
    input  logic                           rx_valid,
    output logic [2:0]                     rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output matrix_pkg::fb_write_t          fb_write
);
    localparam int COL_W = `COL_BITS;
    localparam int ROW_W = `ROW_BITS;
    localparam int SEL_W = $clog2(`BYTES_PER_PIXEL);
    localparam int PLANE_W = $clog2(`BRIGHTNESS_LEVELS);

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`MATRIX_WIDTH - 1);
    localparam logic [SEL_W-1:0] HIGH_SEL = SEL_W'(`BYTES_PER_PIXEL - 1);

    // parser states
    localparam logic [1:0] ST_CMD  = 2'd0;
    localparam logic [1:0] ST_ROW  = 2'd1;
    localparam logic [1:0] ST_LOAD = 2'd2;

    logic [1:0]                 state;
    logic [ROW_W-1:0]           row_q;
    logic [COL_W-1:0]           col_q;
    logic [SEL_W-1:0]           sel_q;
    logic                       last_byte;
    logic [PLANE_W-1:0]         plane_idx;

    logic                        wr_strobe;
    logic [`PIXEL_ADDR_BITS-1:0] wr_addr;
    logic [SEL_W-1:0]            wr_sel;
    logic [7:0]                  wr_data;

    // digit 1 is the top plane, digit 6 the bottom one
    assign plane_idx = PLANE_W'(`BRIGHTNESS_LEVELS) - rx_data[PLANE_W-1:0];

    // low byte of the last column ends the line
    assign last_byte = (col_q == LAST_COL) && (sel_q == '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= ST_CMD;
            rgb_enable        <= 3'b111;
            brightness_enable <= '1;
            wr_strobe         <= 1'b0;
            row_q             <= '0;
            col_q             <= '0;
            sel_q             <= '0;
        end else begin
            wr_strobe <= 1'b0;
            if (rx_valid) begin
                case (state)
                    ST_CMD: begin
                        case (rx_data)
                            "R": rgb_enable[0] <= 1'b1;
                            "r": rgb_enable[0] <= 1'b0;
                            "G": rgb_enable[1] <= 1'b1;
                            "g": rgb_enable[1] <= 1'b0;
                            "B": rgb_enable[2] <= 1'b1;
                            "b": rgb_enable[2] <= 1'b0;
                            "1", "2", "3", "4", "5", "6": begin
                                brightness_enable[plane_idx] <= ~brightness_enable[plane_idx];
                            end
                            "0": brightness_enable <= '0;
                            "9": brightness_enable <= '1;
                            "L": state <= ST_ROW;
                            default: begin
                            end
                        endcase
                    end
                    ST_ROW: begin
                        // a repeated L is not a row number
                        if (rx_data != "L") begin
                            row_q <= rx_data[ROW_W-1:0];
                            col_q <= '0;
                            sel_q <= HIGH_SEL;
                            state <= ST_LOAD;
                        end
                    end
                    ST_LOAD: begin
                        wr_strobe <= 1'b1;
                        if (sel_q == '0) begin
                            sel_q <= HIGH_SEL;
                            col_q <= col_q + 1'b1;
                        end else begin
                            sel_q <= sel_q - 1'b1;
                        end
                        if (last_byte) begin
                            state <= ST_CMD;
                        end
                    end
                    default: state <= ST_CMD;
                endcase
            end
        end
    end

    // address, byte select and data that go with the write strobe
    always_ff @(posedge clk_in) begin
        if (rx_valid && state == ST_LOAD) begin
            wr_addr <= {row_q, col_q};
            wr_sel  <= sel_q;
            wr_data <= rx_data;
        end
    end

    assign fb_write.strobe   = wr_strobe;
    assign fb_write.addr     = wr_addr;
    assign fb_write.byte_sel = wr_sel;
    assign fb_write.data     = wr_data;

endmodule

//--- logic/frame_arbiter.sv
`timescale 1ns/1ns

module frame_arbiter (
    input  matrix_pkg::fb_write_t fb_write,
    input  matrix_pkg::fb_read_t  fb_read,
    output logic                  read_grant,
    output matrix_pkg::mem_port_t mem_port
);

    // the parser cannot stall, so its write always wins
    always_comb begin
        mem_port   = '0;
        read_grant = 1'b0;

        if (fb_write.strobe) begin
            mem_port.enable = 1'b1;
            mem_port.write  = 1'b1;
            mem_port.addr   = fb_write.addr;

            // single byte lane store
            mem_port.byte_en[fb_write.byte_sel]     = 1'b1;
            mem_port.wdata.bytes[fb_write.byte_sel] = fb_write.data;
        end else if (fb_read.req) begin
            mem_port.enable = 1'b1;
            mem_port.write  = 1'b0;
            mem_port.addr   = fb_read.addr;

            // scanner sees this and drops its request next cycle
            read_grant = 1'b1;
        end
    end

endmodule

//--- logic/frame_memory.sv
`timescale 1ns/1ns
`include "matrix_params.svh"

module frame_memory (
    input  logic                  clk_in,
    input  matrix_pkg::mem_port_t mem_port,
    output matrix_pkg::pixel_word_t rd_data
);
    import matrix_pkg::*;

    localparam int DEPTH = `MATRIX_WIDTH * `MATRIX_HEIGHT;

    // one word per pixel, indexed by {row, col}
    pixel_word_t mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (mem_port.enable) begin
            if (mem_port.write) begin
                for (int b = 0; b < `BYTES_PER_PIXEL; b++) begin
                    if (mem_port.byte_en[b]) begin
                        mem[mem_port.addr].bytes[b] <= mem_port.wdata.bytes[b];
                    end
                end
            end else begin
                // read data valid the cycle after the grant
                rd_data <= mem[mem_port.addr];
            end
        end
    end

endmodule

//--- logic/row_scanner.sv
`timescale 1ns/1ns
`include "matrix_params.svh"

module row_scanner (
    input  logic                           clk_in,
    input  logic                           reset,
    input  logic                           read_grant,
    input  matrix_pkg::pixel_word_t        rd_data,
    input  logic [2:0]                     rgb_enable,
    input  logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output matrix_pkg::fb_read_t           fb_read,
    output logic                           pixel_valid,
    output matrix_pkg::scan_pixel_t        pixel
);
    import matrix_pkg::*;

    localparam int COL_W = `COL_BITS;
    localparam int ROW_W = `ROW_BITS;

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`MATRIX_WIDTH - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`MATRIX_HEIGHT - 1);

    // request, data return, pixel shown
    localparam logic [1:0] S_REQ  = 2'd0;
    localparam logic [1:0] S_DATA = 2'd1;
    localparam logic [1:0] S_SHOW = 2'd2;

    logic [1:0]       state;
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;
    logic [4:0]       rb_mask;
    logic [5:0]       g_mask;
    rgb565_t          masked;

    assign fb_read.req  = (state == S_REQ);
    assign fb_read.addr = {row_q, col_q};

    // red and blue line up with the top five green bits
    assign g_mask  = brightness_enable;
    assign rb_mask = brightness_enable[`BRIGHTNESS_LEVELS-1:1];

    always_comb begin
        masked.red   = rd_data.color.red   & rb_mask & {5{rgb_enable[0]}};
        masked.green = rd_data.color.green & g_mask  & {6{rgb_enable[1]}};
        masked.blue  = rd_data.color.blue  & rb_mask & {5{rgb_enable[2]}};
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= S_REQ;
            row_q       <= '0;
            col_q       <= '0;
            pixel_valid <= 1'b0;
        end else begin
            case (state)
                S_REQ: begin
                    if (read_grant) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    pixel_valid <= 1'b1;
                    state       <= S_SHOW;
                end
                S_SHOW: begin
                    pixel_valid <= 1'b0;
                    state       <= S_REQ;
                    // column first, then row, wrapping at frame end
                    if (col_q == LAST_COL) begin
                        col_q <= '0;
                        row_q <= (row_q == LAST_ROW) ? '0 : row_q + 1'b1;
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                default: state <= S_REQ;
            endcase
        end
    end

    // masks sampled when the word comes back
    always_ff @(posedge clk_in) begin
        if (state == S_DATA) begin
            pixel.row   <= row_q;
            pixel.col   <= col_q;
            pixel.color <= masked;
        end
    end

endmodule

//--- logic/matrix_top.sv
`timescale 1ns/1ns
`include "matrix_params.svh"

module matrix_top (
    input  logic                           clk_in,
    input  logic                           reset,
    input  logic [7:0]                     rx_data,
    input  logic                           rx_valid,
    output logic [2:0]                     rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic                           pixel_valid,
    output matrix_pkg::scan_pixel_t        pixel
);
    import matrix_pkg::*;

    fb_write_t   fb_write;
    fb_read_t    fb_read;
    logic        read_grant;
    mem_port_t   mem_port;
    pixel_word_t rd_data;

    command_parser command_parser_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .fb_write          (fb_write)
    );

    // write has priority, scanner waits
    frame_arbiter frame_arbiter_inst (
        .fb_write   (fb_write),
        .fb_read    (fb_read),
        .read_grant (read_grant),
        .mem_port   (mem_port)
    );

    frame_memory frame_memory_inst (
        .clk_in   (clk_in),
        .mem_port (mem_port),
        .rd_data  (rd_data)
    );

    row_scanner row_scanner_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .read_grant        (read_grant),
        .rd_data           (rd_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .fb_read           (fb_read),
        .pixel_valid       (pixel_valid),
        .pixel             (pixel)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk_in,
    output logic reset
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_in = 1'b0;
        forever #HALF_PERIOD clk_in = ~clk_in;
    end

    // released 1 ns after the edge as the other inputs are
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1 reset = 1'b0;
    end

endmodule

//--- test/matrix_tb.sv
`timescale 1ns/1ns
`include "matrix_params.svh"

module matrix_tb;
    import matrix_pkg::*;

    localparam int WIDTH    = `MATRIX_WIDTH;
    localparam int HEIGHT   = `MATRIX_HEIGHT;
    localparam int BPP      = `BYTES_PER_PIXEL;
    localparam int LEVELS   = `BRIGHTNESS_LEVELS;
    localparam int ROW_W    = `ROW_BITS;
    localparam int COL_W    = `COL_BITS;
    localparam int PIXELS   = WIDTH * HEIGHT;

    localparam int NUM_ROUNDS   = 6;
    localparam int CMD_BYTES    = 24;
    // L, optional second L, row byte, optional replacement row, pixel data
    localparam int LINE_BYTES   = 4 + BPP * WIDTH;
    localparam int TOTAL_BYTES  = (HEIGHT + NUM_ROUNDS) * LINE_BYTES + NUM_ROUNDS * CMD_BYTES;
    localparam int FRAME_CYCLES = PIXELS * 3;
    localparam int QUIET_CYCLES = 3 * FRAME_CYCLES + 8;
    localparam int QUIET_FRAMES = (NUM_ROUNDS + 1) * 3;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 4 + QUIET_FRAMES * PIXELS * 4 + 2000;

    localparam int M_CMD  = 0;
    localparam int M_ROW  = 1;
    localparam int M_LOAD = 2;

    logic              clk_in;
    logic              reset;
    logic [7:0]        rx_data;
    logic              rx_valid;
    logic [2:0]        rgb_enable;
    logic [LEVELS-1:0] brightness_enable;
    logic              pixel_valid;
    scan_pixel_t       pixel;

    // reference model
    int                model_state;
    int                model_row;
    int                model_col;
    int                model_sel;
    logic [2:0]        model_rgb;
    logic [LEVELS-1:0] model_bright;
    logic [15:0]       model_mem [PIXELS];

    logic [15:0] lfsr_state;
    logic        quiet;
    int          zero_count;
    int          checked_count;
    logic        grant_seen;
    int          scan_row;
    int          scan_col;
    int          round;
    int          r;

    tb_clock tb_clock_inst (
        .clk_in (clk_in),
        .reset  (reset)
    );

    matrix_top matrix_top_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .pixel_valid       (pixel_valid),
        .pixel             (pixel)
    );

    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        // galois form with taps 16 14 13 11
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end else begin
            return state >> 1;
        end
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_enables(input logic [2:0] got_rgb, input logic [2:0] exp_rgb,
                                 input logic [LEVELS-1:0] got_b,
                                 input logic [LEVELS-1:0] exp_b);
        if (got_rgb !== exp_rgb) begin
            report_failure($sformatf("[ERROR] %0t rgb_enable got %b expected %b",
                                     $time, got_rgb, exp_rgb));
        end
        if (got_b !== exp_b) begin
            report_failure($sformatf("[ERROR] %0t brightness_enable got %b expected %b",
                                     $time, got_b, exp_b));
        end
    endtask

    task automatic check_pixel(input scan_pixel_t got, input scan_pixel_t exp,
                               input logic with_color);
        if (got.row !== exp.row || got.col !== exp.col) begin
            report_failure($sformatf("[ERROR] %0t pixel.row/col got (%0d,%0d) expected (%0d,%0d)",
                                     $time, got.row, got.col, exp.row, exp.col));
        end
        if (with_color && got.color !== exp.color) begin
            report_failure($sformatf("[ERROR] %0t pixel.color at (%0d,%0d) got %h expected %h",
                                     $time, exp.row, exp.col, got.color, exp.color));
        end
    endtask

    // command rules as the parser should apply them
    function automatic void model_byte(input logic [7:0] b);
        int plane;
        int addr;
        case (model_state)
            M_CMD: begin
                case (b)
                    "R": model_rgb[0] = 1'b1;
                    "r": model_rgb[0] = 1'b0;
                    "G": model_rgb[1] = 1'b1;
                    "g": model_rgb[1] = 1'b0;
                    "B": model_rgb[2] = 1'b1;
                    "b": model_rgb[2] = 1'b0;
                    "1", "2", "3", "4", "5", "6": begin
                        // digit 1 toggles the top plane
                        plane = LEVELS - (int'(b) - 48);
                        model_bright[plane] = ~model_bright[plane];
                    end
                    "0": model_bright = '0;
                    "9": model_bright = '1;
                    "L": model_state = M_ROW;
                    default: begin
                    end
                endcase
            end
            M_ROW: begin
                if (b != "L") begin
                    model_row   = int'(b) % HEIGHT;
                    model_col   = 0;
                    model_sel   = BPP - 1;
                    model_state = M_LOAD;
                end
            end
            default: begin
                addr = model_row * WIDTH + model_col;
                model_mem[addr][model_sel*8 +: 8] = b;
                if (model_sel == 0) begin
                    if (model_col == WIDTH - 1) begin
                        model_state = M_CMD;
                    end
                    model_col = model_col + 1;
                    model_sel = BPP - 1;
                end else begin
                    model_sel = model_sel - 1;
                end
            end
        endcase
    endfunction

    function automatic scan_pixel_t expected_pixel(input int row, input int col);
        logic [15:0] word;
        logic [4:0]  red;
        logic [5:0]  green;
        logic [4:0]  blue;
        scan_pixel_t p;
        int          k;
        word  = model_mem[row * WIDTH + col];
        red   = word[15:11];
        green = word[10:5];
        blue  = word[4:0];
        if (!model_rgb[0]) red = '0;
        if (!model_rgb[1]) green = '0;
        if (!model_rgb[2]) blue = '0;
        for (k = 0; k < LEVELS; k++) begin
            if (!model_bright[k]) begin
                green[k] = 1'b0;
                // red and blue sit one bit lower than green
                if (k >= 1) begin
                    red[k-1]  = 1'b0;
                    blue[k-1] = 1'b0;
                end
            end
        end
        p.row         = ROW_W'(row);
        p.col         = COL_W'(col);
        p.color.red   = red;
        p.color.green = green;
        p.color.blue  = blue;
        return p;
    endfunction

    // one byte, then a random gap of 0 to 3 cycles
    task automatic send_byte(input logic [7:0] b);
        int gap;
        rx_data  = b;
        rx_valid = 1'b1;
        @(posedge clk_in);
        #1;
        rx_valid = 1'b0;
        model_byte(b);
        check_enables(rgb_enable, model_rgb, brightness_enable, model_bright);
        gap = int'(random_bits(2));
        repeat (gap) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    function automatic logic [7:0] command_byte(input logic [3:0] idx);
        logic [7:0] b;
        case (idx)
            4'd0:  b = "R";
            4'd1:  b = "r";
            4'd2:  b = "G";
            4'd3:  b = "g";
            4'd4:  b = "B";
            4'd5:  b = "b";
            4'd6:  b = "0";
            4'd7:  b = "1";
            4'd8:  b = "2";
            4'd9:  b = "3";
            4'd10: b = "4";
            4'd11: b = "5";
            4'd12: b = "6";
            4'd13: b = "9";
            4'd14: b = "7";
            default: begin
                // unknown byte, but never the start of a line
                b = 8'(random_bits(8));
                if (b == "L") b = "x";
            end
        endcase
        return b;
    endfunction

    task automatic send_commands(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            send_byte(command_byte(4'(random_bits(4))));
        end
    endtask

    task automatic send_line(input int row);
        logic [7:0] row_byte;
        int         i;
        send_byte("L");
        if (random_bits(1) == 1) begin
            send_byte("L");
        end
        row_byte = 8'((random_bits(8 - ROW_W) << ROW_W) | row);
        if (row_byte == "L") begin
            send_byte(row_byte);
            row_byte = 8'(row);
        end
        send_byte(row_byte);
        for (i = 0; i < WIDTH * BPP; i++) begin
            send_byte(8'(random_bits(8)));
        end
    endtask

    // pause long enough to skip one frame and check the next one whole
    task automatic check_quiet_frame();
        zero_count    = 0;
        checked_count = 0;
        quiet         = 1'b1;
        repeat (QUIET_CYCLES) begin
            @(posedge clk_in);
            #1;
        end
        quiet = 1'b0;
        if (checked_count != PIXELS) begin
            report_failure($sformatf("quiet window ended with only %0d of %0d pixels checked",
                                     checked_count, PIXELS));
        end
        check_enables(rgb_enable, model_rgb, brightness_enable, model_bright);
    endtask

    initial begin : pixel_monitor
        scan_pixel_t expected;
        logic        with_color;
        @(negedge reset);
        forever begin
            @(negedge clk_in);
            if (pixel_valid) begin
                if (!grant_seen) begin
                    report_failure("pixel_valid was seen before any read grant");
                end
                if (quiet && scan_row == 0 && scan_col == 0) zero_count++;
                expected   = expected_pixel(scan_row, scan_col);
                with_color = quiet && zero_count == 2 && checked_count < PIXELS;
                check_pixel(pixel, expected, with_color);
                if (with_color) checked_count++;
                // step in scan order with the column first
                if (scan_col == WIDTH - 1) begin
                    scan_col = 0;
                    scan_row = (scan_row == HEIGHT - 1) ? 0 : scan_row + 1;
                end else begin
                    scan_col = scan_col + 1;
                end
            end
            if (matrix_top_inst.read_grant) grant_seen = 1'b1;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        report_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        rx_data       = 8'h00;
        rx_valid      = 1'b0;
        lfsr_state    = 16'd18303;
        quiet         = 1'b0;
        zero_count    = 0;
        checked_count = 0;
        grant_seen    = 1'b0;
        scan_row      = 0;
        scan_col      = 0;
        model_state   = M_CMD;
        model_row     = 0;
        model_col     = 0;
        model_sel     = 0;
        model_rgb     = 3'b111;
        model_bright  = '1;

        @(negedge reset);
        check_enables(rgb_enable, 3'b111, brightness_enable, '1);

        // every row gets known contents first
        for (r = 0; r < HEIGHT; r++) begin
            send_line(r);
        end
        check_quiet_frame();

        for (round = 0; round < NUM_ROUNDS; round++) begin
            send_commands(CMD_BYTES);
            send_line(int'(random_bits(ROW_W)));
            check_quiet_frame();
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/matrix_pkg.sv
logic/command_parser.sv
logic/frame_arbiter.sv
logic/frame_memory.sv
logic/row_scanner.sv
logic/matrix_top.sv
test/tb_clock.sv
test/matrix_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module matrix_tb \
    -f verilog.f -o matrix_sim

# $fatal gives a nonzero exit, the log decides the result
./obj_dir/matrix_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    exit 1
fi
